//--- flist.f
src/i2c_bus_pkg.sv
src/axis_beat_pkg.sv
src/i2c_line_sync.sv
src/i2c_byte_shifter.sv
src/i2c_target_ctrl.sv
src/stream_assembler.sv
src/axis_fifo.sv
src/i2c_axis_target_top.sv
bench/stream_checker.sv
bench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the I2C target simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_top -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- bench/tb_top.sv
// ----------------------------------------
// Testbench for the I2C write target
// Bit-banged controller, transfer table, ready patterns
// ----------------------------------------
`default_nettype none

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          FIFO_DEPTH   = 4;
    localparam logic [6:0]  PRIM_ADDR    = 7'h2a;
    localparam logic [6:0]  SEC_ADDR     = 7'h51;
    localparam int          HALF         = 10;
    localparam int          HOLD         = 2;
    localparam int          RESET_CYCLES = 10;
    localparam int          DRAIN_LIMIT  = 4000;
    localparam int          N_XFERS      = 9;
    localparam logic [31:0] SEED         = 32'hd12c_a72c;

    // Ready modes
    localparam logic [1:0] RDY_ALWAYS = 2'd0;
    localparam logic [1:0] RDY_STALL  = 2'd1;
    localparam logic [1:0] RDY_RANDOM = 2'd2;

    // One row of the transfer table
    typedef struct packed {
        logic [6:0] addr;
        logic       rw;
        logic [3:0] n_bytes;
        logic [7:0] first;
        logic       rep_start;
        logic [1:0] ready_mode;
    } xfer_t;

    logic                      clk;
    logic                      rst;
    logic                      scl;
    logic                      sda_drv;
    logic                      sda_line;
    logic                      sda_pull_low;
    axis_beat_pkg::axis_beat_t m_axis_beat;
    logic                      m_axis_valid;
    logic                      m_axis_ready;
    logic [1:0]                ready_mode;
    logic                      bus_held;

    logic                      exp_push;
    axis_beat_pkg::axis_beat_t exp_beat;
    logic                      ack_strobe;
    logic                      ack_got;
    logic                      ack_want;
    int                        beat_errors;
    int                        ack_errors;
    int                        pending;
    int                        timeout_errors;

    xfer_t xfers [N_XFERS];

    // Open-drain wired AND of controller and target
    assign sda_line = sda_drv & ~sda_pull_low;

    i2c_axis_target_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .primary_addr   (PRIM_ADDR),
        .secondary_addr (SEC_ADDR),
        .scl            (scl),
        .sda_in         (sda_line),
        .sda_pull_low   (sda_pull_low),
        .m_axis_beat    (m_axis_beat),
        .m_axis_valid   (m_axis_valid),
        .m_axis_ready   (m_axis_ready)
    );

    stream_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .m_axis_beat  (m_axis_beat),
        .m_axis_valid (m_axis_valid),
        .m_axis_ready (m_axis_ready),
        .exp_push     (exp_push),
        .exp_beat     (exp_beat),
        .ack_strobe   (ack_strobe),
        .ack_got      (ack_got),
        .ack_want     (ack_want),
        .beat_errors  (beat_errors),
        .ack_errors   (ack_errors),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        case (ready_mode)
            RDY_STALL:  m_axis_ready <= 1'b0;
            RDY_RANDOM: m_axis_ready <= 1'($urandom_range(0, 1));
            default:    m_axis_ready <= 1'b1;
        endcase
    end

    // ----------------------------------------
    // Bus and handoff tasks
    // ----------------------------------------
    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic clock_bit(input logic b, output logic seen);
        sda_drv = b;
        wait_clocks(HALF);
        scl = 1'b1;
        wait_clocks(HALF / 2);
        seen = sda_line;
        wait_clocks(HALF - HALF / 2);
        scl = 1'b0;
        wait_clocks(HOLD);
    endtask

    // Returns 1 when the target pulled SDA low in the ninth slot
    task automatic send_byte(input logic [7:0] b, output logic ack);
        logic seen;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(b[i], seen);
        end
        clock_bit(1'b1, seen);
        ack = !seen;
    endtask

    task automatic send_start(input logic restart);
        if (restart) begin
            sda_drv = 1'b1;
            wait_clocks(HALF);
            scl = 1'b1;
            wait_clocks(HALF);
        end
        sda_drv = 1'b0;
        wait_clocks(HALF);
        scl = 1'b0;
        wait_clocks(HOLD);
    endtask

    task automatic send_stop();
        sda_drv = 1'b0;
        wait_clocks(HALF);
        scl = 1'b1;
        wait_clocks(HALF);
        sda_drv = 1'b1;
        wait_clocks(HALF);
    endtask

    task automatic expect_beat(input axis_beat_pkg::axis_beat_t beat);
        exp_beat = beat;
        exp_push = 1'b1;
        @(negedge clk);
        exp_push = 1'b0;
    endtask

    task automatic report_ack(input logic got, input logic want);
        ack_got    = got;
        ack_want   = want;
        ack_strobe = 1'b1;
        @(negedge clk);
        ack_strobe = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (pending != 0) begin
            $display("Timeout: %0d expected beats never reached the stream output", pending);
            timeout_errors++;
        end
    endtask

    // ----------------------------------------
    // One table row, expectations first
    // ----------------------------------------
    task automatic run_transfer(input xfer_t x);
        logic [7:0]                     data [16];
        logic [axis_beat_pkg::ID_W-1:0] id;
        axis_beat_pkg::axis_beat_t      beat;
        logic                           addr_want;
        logic                           got;
        int                             n_exp;
        for (int i = 0; i < int'(x.n_bytes); i++) begin
            data[i] = (x.ready_mode == RDY_RANDOM) ? 8'($urandom) : x.first + 8'(i);
        end
        addr_want = ((x.addr == PRIM_ADDR) || (x.addr == SEC_ADDR)) && !x.rw;
        id = (x.addr == PRIM_ADDR) ? '0 : (axis_beat_pkg::ID_W)'(1);
        n_exp = int'(x.n_bytes);
        if (!addr_want) begin
            n_exp = 0;
        end else if (x.ready_mode == RDY_STALL && n_exp > FIFO_DEPTH) begin
            // Stalled stream takes exactly FIFO_DEPTH bytes
            n_exp = FIFO_DEPTH;
        end
        for (int k = 0; k < n_exp; k++) begin
            beat.data = data[k];
            beat.last = (k == n_exp - 1);
            beat.id   = id;
            expect_beat(beat);
        end

        ready_mode <= x.ready_mode;
        if (!bus_held) begin
            send_start(1'b0);
        end
        send_byte({x.addr, x.rw}, got);
        report_ack(got, addr_want);
        for (int i = 0; i < int'(x.n_bytes) && got; i++) begin
            send_byte(data[i], got);
            report_ack(got, (x.ready_mode != RDY_STALL) || (i < FIFO_DEPTH));
        end
        if (x.rep_start) begin
            send_start(1'b1);
            bus_held = 1'b1;
        end else begin
            send_stop();
            bus_held = 1'b0;
        end
        ready_mode <= RDY_ALWAYS;
        wait_drain();
    endtask

    initial begin
        int total;
        void'($urandom(SEED));
        rst            = 1'b1;
        scl            = 1'b1;
        sda_drv        = 1'b1;
        m_axis_ready   = 1'b1;
        ready_mode     = RDY_ALWAYS;
        bus_held       = 1'b0;
        exp_push       = 1'b0;
        exp_beat       = '0;
        ack_strobe     = 1'b0;
        ack_got        = 1'b0;
        ack_want       = 1'b0;
        timeout_errors = 0;

        xfers[0] = '{addr: PRIM_ADDR, rw: 1'b0, n_bytes: 4'd3, first: 8'h10,
                     rep_start: 1'b0, ready_mode: RDY_ALWAYS};
        xfers[1] = '{addr: SEC_ADDR, rw: 1'b0, n_bytes: 4'd2, first: 8'h40,
                     rep_start: 1'b0, ready_mode: RDY_ALWAYS};
        // Unmatched address, then a read to a matching one
        xfers[2] = '{addr: 7'h33, rw: 1'b0, n_bytes: 4'd2, first: 8'h00,
                     rep_start: 1'b0, ready_mode: RDY_ALWAYS};
        xfers[3] = '{addr: PRIM_ADDR, rw: 1'b1, n_bytes: 4'd2, first: 8'h20,
                     rep_start: 1'b0, ready_mode: RDY_ALWAYS};
        xfers[4] = '{addr: PRIM_ADDR, rw: 1'b0, n_bytes: 4'(FIFO_DEPTH + 1), first: 8'h80,
                     rep_start: 1'b0, ready_mode: RDY_STALL};
        xfers[5] = '{addr: PRIM_ADDR, rw: 1'b0, n_bytes: 4'd2, first: 8'hc0,
                     rep_start: 1'b1, ready_mode: RDY_ALWAYS};
        xfers[6] = '{addr: SEC_ADDR, rw: 1'b0, n_bytes: 4'd3, first: 8'h00,
                     rep_start: 1'b1, ready_mode: RDY_RANDOM};
        xfers[7] = '{addr: PRIM_ADDR, rw: 1'b0, n_bytes: 4'd8, first: 8'h00,
                     rep_start: 1'b0, ready_mode: RDY_RANDOM};
        xfers[8] = '{addr: SEC_ADDR, rw: 1'b0, n_bytes: 4'd6, first: 8'h00,
                     rep_start: 1'b0, ready_mode: RDY_RANDOM};

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        wait_clocks(20);

        for (int idx = 0; idx < N_XFERS; idx++) begin
            run_transfer(xfers[idx]);
        end
        wait_clocks(20);

        total = beat_errors + ack_errors + timeout_errors;
        $display("Errors: %0d beat, %0d ack, %0d timeout", beat_errors, ack_errors,
                 timeout_errors);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/stream_checker.sv
// ----------------------------------------
// Stream output checker
// Compares beats and ACK results, counts errors
// ----------------------------------------
`default_nettype none

module stream_checker (
    input  wire                             clk,
    input  wire                             rst,
    input  wire axis_beat_pkg::axis_beat_t  m_axis_beat,
    input  wire                             m_axis_valid,
    input  wire                             m_axis_ready,
    input  wire                             exp_push,
    input  wire axis_beat_pkg::axis_beat_t  exp_beat,
    input  wire                             ack_strobe,
    input  wire                             ack_got,
    input  wire                             ack_want,
    output int                              beat_errors,
    output int                              ack_errors,
    output int                              pending
);

    timeunit 1ns;
    timeprecision 100ps;

    axis_beat_pkg::axis_beat_t exp_q [$];
    axis_beat_pkg::axis_beat_t want;
    axis_beat_pkg::axis_beat_t held_beat;
    logic                      held;

    initial begin
        beat_errors = 0;
        ack_errors  = 0;
        pending     = 0;
        held        = 1'b0;
        held_beat   = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            held = 1'b0;
        end else begin
            // ----------------------------------------
            // A stalled beat must stay put
            // ----------------------------------------
            if (held) begin
                if (!m_axis_valid) begin
                    $display("Mismatch m_axis_valid: got %h expected %h at %0t",
                             m_axis_valid, 1'b1, $time);
                    beat_errors++;
                end else if (m_axis_beat != held_beat) begin
                    $display("Mismatch m_axis_beat (stalled): got %h expected %h at %0t",
                             m_axis_beat, held_beat, $time);
                    beat_errors++;
                end
            end

            if (exp_push) begin
                exp_q.push_back(exp_beat);
            end

            // Beat accepted on this edge
            if (m_axis_valid && m_axis_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected beat on the stream output: data %h last %h id %h",
                             m_axis_beat.data, m_axis_beat.last, m_axis_beat.id);
                    beat_errors++;
                end else begin
                    want = exp_q.pop_front();
                    if (m_axis_beat != want) begin
                        $display("Mismatch m_axis_beat: got %h expected %h at %0t",
                                 m_axis_beat, want, $time);
                        beat_errors++;
                    end
                end
            end

            if (ack_strobe && (ack_got != ack_want)) begin
                $display("Mismatch sda_ack: got %h expected %h at %0t",
                         ack_got, ack_want, $time);
                ack_errors++;
            end

            held      = m_axis_valid && !m_axis_ready;
            held_beat = m_axis_beat;
            pending   = exp_q.size();
        end
    end

endmodule

`default_nettype wire

//--- src/i2c_axis_target_top.sv
// ----------------------------------------
// I2C write target with stream output
// ----------------------------------------
`default_nettype none

module i2c_axis_target_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire [6:0]                       primary_addr,
    input  wire [6:0]                       secondary_addr,
    input  wire                             scl,
    input  wire                             sda_in,
    output wire                             sda_pull_low,
    output wire axis_beat_pkg::axis_beat_t  m_axis_beat,
    output wire                             m_axis_valid,
    input  wire                             m_axis_ready
);

    i2c_bus_pkg::bus_event_t        events;
    logic                           byte_clear;
    logic                           byte_done;
    logic [7:0]                     rx_byte;
    logic                           room_two;
    logic                           push;
    logic                           flush;
    logic [axis_beat_pkg::ID_W-1:0] hit_id;
    logic [7:0]                     data_byte;
    logic                           wr_en;
    axis_beat_pkg::axis_beat_t      wr_beat;

    // ----------------------------------------
    // Bus side
    // ----------------------------------------
    i2c_line_sync u_line_sync (
        .clk    (clk),
        .rst    (rst),
        .scl    (scl),
        .sda_in (sda_in),
        .events (events)
    );

    i2c_byte_shifter u_byte_shifter (
        .clk        (clk),
        .rst        (rst),
        .events     (events),
        .byte_clear (byte_clear),
        .byte_done  (byte_done),
        .rx_byte    (rx_byte)
    );

    i2c_target_ctrl u_target_ctrl (
        .clk            (clk),
        .rst            (rst),
        .events         (events),
        .byte_done      (byte_done),
        .rx_byte        (rx_byte),
        .primary_addr   (primary_addr),
        .secondary_addr (secondary_addr),
        .room_two       (room_two),
        .byte_clear     (byte_clear),
        .sda_pull_low   (sda_pull_low),
        .push           (push),
        .flush          (flush),
        .hit_id         (hit_id),
        .data_byte      (data_byte)
    );

    // ----------------------------------------
    // Stream side
    // ----------------------------------------
    stream_assembler u_assembler (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .flush     (flush),
        .data_byte (data_byte),
        .hit_id    (hit_id),
        .wr_en     (wr_en),
        .wr_beat   (wr_beat)
    );

    axis_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (wr_en),
        .wr_beat      (wr_beat),
        .m_axis_beat  (m_axis_beat),
        .m_axis_valid (m_axis_valid),
        .m_axis_ready (m_axis_ready),
        .room_two     (room_two)
    );

endmodule

`default_nettype wire

//--- src/axis_fifo.sv
// ----------------------------------------
// Stream beat FIFO
// Circular buffer with valid/ready output
// ----------------------------------------
`default_nettype none

module axis_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             wr_en,
    input  wire axis_beat_pkg::axis_beat_t  wr_beat,
    output axis_beat_pkg::axis_beat_t       m_axis_beat,
    output logic                            m_axis_valid,
    input  wire                             m_axis_ready,
    output logic                            room_two
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    axis_beat_pkg::axis_beat_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    // Wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full         = (count == CNT_W'(FIFO_DEPTH));
    assign do_wr        = wr_en && !full;
    assign do_rd        = m_axis_valid && m_axis_ready;
    assign m_axis_valid = (count != '0);
    assign m_axis_beat  = mem[rd_ptr];
    assign room_two     = (count <= CNT_W'(FIFO_DEPTH - 2));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // Upstream room_two rule must keep writes off a full FIFO
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !full
    ) else $error("Write into full FIFO");

endmodule

`default_nettype wire

//--- src/stream_assembler.sv
// ----------------------------------------
// Stream assembler
// Holds one byte back so it can carry last
// ----------------------------------------
`default_nettype none

module stream_assembler (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             push,
    input  wire                             flush,
    input  wire [7:0]                       data_byte,
    input  wire [axis_beat_pkg::ID_W-1:0]   hit_id,
    output logic                            wr_en,
    output axis_beat_pkg::axis_beat_t       wr_beat
);

    logic                           pending_valid;
    logic [7:0]                     pending_byte;
    logic [axis_beat_pkg::ID_W-1:0] pending_id;

    // Control side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_valid <= 1'b0;
            wr_en         <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (flush) begin
                wr_en         <= pending_valid;
                pending_valid <= 1'b0;
            end else if (push) begin
                // Older byte goes out, new one waits
                wr_en         <= pending_valid;
                pending_valid <= 1'b1;
            end
        end
    end

    // Payload side
    always_ff @(posedge clk) begin
        if (flush || push) begin
            wr_beat.data <= pending_byte;
            wr_beat.last <= flush;
            wr_beat.id   <= pending_id;
        end
        if (push && !flush) begin
            pending_byte <= data_byte;
            pending_id   <= hit_id;
        end
    end

endmodule

`default_nettype wire

//--- src/i2c_target_ctrl.sv
// ----------------------------------------
// I2C target controller
// Dual address match, ACK/NACK and SDA pull-low timing
// ----------------------------------------
`default_nettype none

module i2c_target_ctrl (
    input  wire                             clk,
    input  wire                             rst,
    input  wire i2c_bus_pkg::bus_event_t    events,
    input  wire                             byte_done,
    input  wire [7:0]                       rx_byte,
    input  wire [6:0]                       primary_addr,
    input  wire [6:0]                       secondary_addr,
    input  wire                             room_two,
    output logic                            byte_clear,
    output logic                            sda_pull_low,
    output logic                            push,
    output logic                            flush,
    output logic [axis_beat_pkg::ID_W-1:0]  hit_id,
    output logic [7:0]                      data_byte
);

    i2c_bus_pkg::ctrl_state_t state;

    logic       accepted;
    logic       scl_high;
    logic [6:0] rx_addr;
    logic       prim_hit;
    logic       sec_hit;
    logic       addr_ok;
    logic       data_ok;

    // Address byte decode, write only
    assign rx_addr  = rx_byte[7:1];
    assign prim_hit = (rx_addr == primary_addr);
    assign sec_hit  = (rx_addr == secondary_addr);
    assign addr_ok  = (prim_hit || sec_hit) && !rx_byte[0];
    assign data_ok  = (state == i2c_bus_pkg::ST_DATA) && byte_done && room_two;

    // ----------------------------------------
    // Transfer FSM
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= i2c_bus_pkg::ST_IDLE;
            sda_pull_low <= 1'b0;
            byte_clear   <= 1'b0;
            push         <= 1'b0;
            flush        <= 1'b0;
            accepted     <= 1'b0;
            hit_id       <= '0;
            scl_high     <= 1'b1;
        end else begin
            byte_clear <= 1'b0;
            push       <= 1'b0;
            flush      <= 1'b0;
            if (events.scl_rise) begin
                scl_high <= 1'b1;
            end else if (events.scl_fall) begin
                scl_high <= 1'b0;
            end
            if (events.start || events.stop) begin
                // End of transfer, release the pending byte
                flush        <= accepted;
                accepted     <= 1'b0;
                sda_pull_low <= 1'b0;
                byte_clear   <= events.start;
                state        <= events.start ? i2c_bus_pkg::ST_ADDR : i2c_bus_pkg::ST_IDLE;
            end else begin
                case (state)
                    i2c_bus_pkg::ST_ADDR: begin
                        if (byte_done) begin
                            if (addr_ok) begin
                                // Primary wins when both match
                                hit_id <= prim_hit ? '0 : (axis_beat_pkg::ID_W)'(1);
                                state  <= i2c_bus_pkg::ST_ADDR_ACK;
                            end else begin
                                state <= i2c_bus_pkg::ST_IGNORE;
                            end
                        end
                    end
                    i2c_bus_pkg::ST_ADDR_ACK, i2c_bus_pkg::ST_DATA_ACK: begin
                        // Pull on the 8th fall, release on the 9th
                        if (events.scl_fall) begin
                            if (!sda_pull_low) begin
                                sda_pull_low <= 1'b1;
                            end else begin
                                sda_pull_low <= 1'b0;
                                byte_clear   <= 1'b1;
                                state        <= i2c_bus_pkg::ST_DATA;
                            end
                        end
                    end
                    i2c_bus_pkg::ST_DATA: begin
                        if (data_ok) begin
                            push     <= 1'b1;
                            accepted <= 1'b1;
                            state    <= i2c_bus_pkg::ST_DATA_ACK;
                        end else if (byte_done) begin
                            // No room, NACK and stay off the bus
                            state <= i2c_bus_pkg::ST_IGNORE;
                        end
                    end
                    default: begin
                        // Idle or ignore until START/STOP
                        state <= state;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_ok) begin
            data_byte <= rx_byte;
        end
    end

    // SDA only moves while SCL is low
    a_sda_stable : assert property (
        @(posedge clk) disable iff (rst)
        $changed(sda_pull_low) |-> !scl_high
    ) else $error("sda_pull_low changed while SCL high");

endmodule

`default_nettype wire

//--- src/i2c_byte_shifter.sv
// ----------------------------------------
// I2C byte shifter
// Samples SDA on SCL rise, flags each full byte
// ----------------------------------------
`default_nettype none

module i2c_byte_shifter (
    input  wire                     clk,
    input  wire                     rst,
    input  wire i2c_bus_pkg::bus_event_t events,
    input  wire                     byte_clear,
    output logic                    byte_done,
    output logic [7:0]              rx_byte
);

    // Wraps to zero after the eighth bit
    logic [2:0] bit_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt   <= 3'd0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (byte_clear) begin
                bit_cnt <= 3'd0;
            end else if (events.scl_rise) begin
                bit_cnt   <= bit_cnt + 3'd1;
                byte_done <= (bit_cnt == 3'd7);
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (events.scl_rise) begin
            rx_byte <= {rx_byte[6:0], events.sda};
        end
    end

    // A clear on an SCL rise would lose that bit
    a_clear_not_on_rise : assert property (
        @(posedge clk) disable iff (rst)
        byte_clear |-> !events.scl_rise
    ) else $error("byte_clear coincided with an SCL rise");

endmodule

`default_nettype wire

//--- src/i2c_line_sync.sv
// ----------------------------------------
// I2C line synchronizer
// Syncs SCL/SDA, flags SCL edges, START and STOP
// ----------------------------------------
`default_nettype none

module i2c_line_sync (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     scl,
    input  wire                     sda_in,
    output i2c_bus_pkg::bus_event_t events
);

    // Two-flop synchronizers that idle high
    logic [1:0] scl_ff;
    logic [1:0] sda_ff;
    logic       scl_prev;
    logic       sda_prev;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scl_ff   <= 2'b11;
            sda_ff   <= 2'b11;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end else begin
            scl_ff   <= {scl_ff[0], scl};
            sda_ff   <= {sda_ff[0], sda_in};
            scl_prev <= scl_ff[1];
            sda_prev <= sda_ff[1];
        end
    end

    // ----------------------------------------
    // Registered event decode
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            events <= '{sda: 1'b1, default: 1'b0};
        end else begin
            events.sda      <= sda_ff[1];
            events.scl_rise <= scl_ff[1] & ~scl_prev;
            events.scl_fall <= ~scl_ff[1] & scl_prev;
            // SDA moves while SCL stays high
            events.start    <= scl_ff[1] & scl_prev & sda_prev & ~sda_ff[1];
            events.stop     <= scl_ff[1] & scl_prev & ~sda_prev & sda_ff[1];
        end
    end

    // SDA must not toggle in the same sample as SCL
    a_no_sda_scl_skew : assert property (
        @(posedge clk) disable iff (rst)
        (sda_ff[1] != sda_prev) |-> (scl_ff[1] == scl_prev)
    ) else $error("SDA and SCL changed in the same cycle");

endmodule

`default_nettype wire

//--- src/axis_beat_pkg.sv
// ----------------------------------------
// Stream-side beat types
// ----------------------------------------
`default_nettype none

package axis_beat_pkg;

    // Address id, 0 for primary and 1 for secondary
    parameter int unsigned ID_W = 1;

    // One stream beat
    typedef struct packed {
        logic [7:0]      data;
        logic            last;
        logic [ID_W-1:0] id;
    } axis_beat_t;

endpackage

`default_nettype wire

//--- src/i2c_bus_pkg.sv
// ----------------------------------------
// I2C bus-side types
// Synchronized line events and controller states
// ----------------------------------------
`default_nettype none

package i2c_bus_pkg;

    // One cycle of bus activity, as seen after synchronization
    // start also covers a repeated START
    typedef struct packed {
        logic sda;
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
    } bus_event_t;

    // Target controller states
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_ADDR     = 3'd1,
        ST_ADDR_ACK = 3'd2,
        ST_DATA     = 3'd3,
        ST_DATA_ACK = 3'd4,
        ST_IGNORE   = 3'd5
    } ctrl_state_t;

endpackage

`default_nettype wire
